// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the OCP master testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module ocp_master_tb -o ocp_master_sim \
  && ./obj_dir/ocp_master_sim +verilator+error+limit+1000 2>&1 | tee sim.log

grep -q "^Result: PASSED$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== verification/ocp_master_asserts.sv ====
`timescale 1ns/1ps

module ocp_master_asserts import ocp_master_pkg::*; #(
  parameter int DATA_WIDTH = ocp_master_pkg::DATA_WIDTH
) (
  input logic        Clk,
  input logic        reset,
  input bridge_req_t bridge_req,
  input logic        read_request,
  input logic        write_request,
  input logic        ocp_ready,
  input ocp_req_t    ocp_req,
  input logic        SCmdAccept,
  input ocp_resp_t   ocp_resp,
  input logic        MRespAccept,
  input logic        s_axis_tvalid,
  input logic        s_axis_tready,
  input data_t       s_axis_tdata,
  input logic        s_axis_tlast
);

  // One data word in bytes
  localparam addr_t ADDR_STEP = addr_t'(DATA_WIDTH / 8);

  // Failed assertions so far, polled by the testbench
  int unsigned error_count = 0;

  logic       strobe_taken;
  logic       beat_accept;
  logic       resp_kept;
  burst_len_t beats_seen;

  assign strobe_taken = ocp_ready & (read_request | write_request);
  assign beat_accept  = (ocp_req.cmd != IDLE) & SCmdAccept;
  assign resp_kept    = MRespAccept & ((ocp_resp.resp == DVA) | (ocp_resp.resp == FAIL));

  // Beats accepted so far in this burst
  always_ff @(posedge Clk) begin
    if (reset) begin
      beats_seen <= '0;
    end else if (strobe_taken) begin
      beats_seen <= '0;
    end else if (beat_accept) begin
      beats_seen <= beats_seen + 1'b1;
    end
  end

  // Request frozen while the slave stalls
  a_req_hold: assert property (@(posedge Clk) disable iff (reset)
    (ocp_req.cmd != IDLE && !SCmdAccept) |=> $stable(ocp_req))
    else begin
      error_count++;
      $error("ocp_req changed while SCmdAccept was low");
    end

  // INCR steps one word, other sequences repeat
  a_addr_step: assert property (@(posedge Clk) disable iff (reset)
    (beat_accept && !ocp_req.req_last) |=> ocp_req.addr ==
      $past(ocp_req.addr) + (($past(ocp_req.burst_seq) == INCR) ? ADDR_STEP : '0))
    else begin
      error_count++;
      $error("ocp_req.addr did not follow the burst sequence");
    end

  // First beat carries the sampled bridge fields
  a_first_beat: assert property (@(posedge Clk) disable iff (reset)
    strobe_taken |=> (ocp_req.addr == $past(bridge_req.address) &&
      ocp_req.burst_length == $past(bridge_req.burst_length) &&
      ocp_req.burst_seq == $past(bridge_req.burst_seq)))
    else begin
      error_count++;
      $error("first beat does not match the bridge request");
    end

  // Read wins when both strobes are up
  a_cmd_start: assert property (@(posedge Clk) disable iff (reset)
    strobe_taken |=> ocp_req.cmd == ($past(read_request) ? RD : WR))
    else begin
      error_count++;
      $error("wrong command after a taken strobe");
    end

  // MReqLast on the final beat only
  a_last_beat: assert property (@(posedge Clk) disable iff (reset)
    beat_accept |-> (ocp_req.req_last == (beats_seen == ocp_req.burst_length - 1'b1)))
    else begin
      error_count++;
      $error("req_last does not mark the final beat");
    end

  a_burst_end: assert property (@(posedge Clk) disable iff (reset)
    (beat_accept && ocp_req.req_last) |=> (ocp_req.cmd == IDLE && ocp_ready))
    else begin
      error_count++;
      $error("controller not idle after the final beat");
    end

  // Kept response shows up one cycle later
  a_resp_forward: assert property (@(posedge Clk) disable iff (reset)
    resp_kept |=> (s_axis_tvalid && s_axis_tdata == $past(ocp_resp.data) &&
      s_axis_tlast == $past(ocp_resp.last)))
    else begin
      error_count++;
      $error("response not forwarded onto the stream");
    end

  a_stream_hold: assert property (@(posedge Clk) disable iff (reset)
    (s_axis_tvalid && !s_axis_tready) |=>
      (s_axis_tvalid && $stable(s_axis_tdata) && $stable(s_axis_tlast)))
    else begin
      error_count++;
      $error("stream word dropped or changed under back-pressure");
    end

  // Values out of reset
  a_reset_state: assert property (@(posedge Clk)
    reset |=> (ocp_req.cmd == IDLE && !s_axis_tvalid && ocp_ready && MRespAccept))
    else begin
      error_count++;
      $error("outputs not in their reset state");
    end

endmodule

bind ocp_master_top ocp_master_asserts #(
  .DATA_WIDTH (DATA_WIDTH)
) u_asserts (
  .Clk           (Clk),
  .reset         (reset),
  .bridge_req    (bridge_req),
  .read_request  (read_request),
  .write_request (write_request),
  .ocp_ready     (ocp_ready),
  .ocp_req       (ocp_req),
  .SCmdAccept    (SCmdAccept),
  .ocp_resp      (ocp_resp),
  .MRespAccept   (MRespAccept),
  .s_axis_tvalid (s_axis_tvalid),
  .s_axis_tready (s_axis_tready),
  .s_axis_tdata  (s_axis_tdata),
  .s_axis_tlast  (s_axis_tlast)
);

// ==== verification/ocp_master_tb.sv ====
`timescale 1ns/1ps

module ocp_master_tb
  import ocp_master_pkg::*;
();

  localparam int unsigned RAND_SEED  = 56;
  localparam int          NUM_BURSTS = 30;
  localparam int          WAIT_LIMIT = 2000;
  localparam int          HOLD_LIMIT = 200;

  logic        Clk;
  logic        reset;
  bridge_req_t bridge_req;
  logic        read_request;
  logic        write_request;
  data_t       write_data;
  logic        ocp_ready;
  ocp_req_t    ocp_req;
  logic        SCmdAccept;
  ocp_resp_t   ocp_resp;
  logic        MRespAccept;
  logic        s_axis_tvalid;
  logic        s_axis_tready;
  data_t       s_axis_tdata;
  byte_en_t    s_axis_tkeep;
  logic        s_axis_tlast;

  // Burst in flight
  logic     burst_open;
  logic     burst_is_read;
  addr_t    burst_addr;
  byte_en_t burst_be;
  int       burst_len;
  int       beat_idx;
  data_t    wdata [0:8];
  int       next_data_idx;

  // Slave and sink bookkeeping
  ocp_resp_t resp_pending [$];
  ocp_resp_t stream_expect [$];
  logic      resp_taken;
  int        resp_delay;
  int        resp_hold;
  int        stream_words;

  ocp_master_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) dut (
    .Clk           (Clk),
    .reset         (reset),
    .bridge_req    (bridge_req),
    .read_request  (read_request),
    .write_request (write_request),
    .write_data    (write_data),
    .ocp_ready     (ocp_ready),
    .ocp_req       (ocp_req),
    .SCmdAccept    (SCmdAccept),
    .ocp_resp      (ocp_resp),
    .MRespAccept   (MRespAccept),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tlast  (s_axis_tlast)
  );

  initial begin
    Clk = 1'b0;
    forever begin
      #10 Clk = ~Clk;
    end
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Mostly DVA, some FAIL and ERR
  function automatic ocp_resp_e pick_response();
    int unsigned roll;
    roll = $urandom % 8;
    if (roll < 5) begin
      return DVA;
    end else if (roll < 7) begin
      return FAIL;
    end
    return ERR;
  endfunction

  // Stream word popped against the expected queue
  task automatic track_stream();
    ocp_resp_t exp;
    if (s_axis_tvalid && s_axis_tready) begin
      if (stream_expect.size() == 0) begin
        stop_with_failure("Stream word appeared with no DVA or FAIL response behind it");
      end
      exp = stream_expect.pop_front();
      check_value("s_axis_tdata", 64'(s_axis_tdata), 64'(exp.data));
      check_value("s_axis_tlast", 64'(s_axis_tlast), 64'(exp.last));
      check_value("s_axis_tkeep", 64'(s_axis_tkeep), 64'({DATA_WIDTH{1'b1}}));
      stream_words++;
    end
  endtask

  // ERR is swallowed by the master
  task automatic track_response();
    if (ocp_resp.resp != NULL && MRespAccept) begin
      if (ocp_resp.resp != ERR) begin
        stream_expect.push_back(ocp_resp);
      end
      resp_taken = 1'b1;
    end
  endtask

  task automatic track_request_beat();
    ocp_resp_t rsp;
    if (ocp_req.cmd != IDLE && SCmdAccept) begin
      if (!burst_open) begin
        stop_with_failure("Request beat accepted with no burst in progress");
      end
      if (beat_idx == 0) begin
        check_value("ocp_req.addr", ocp_req.addr, burst_addr);
      end
      check_value("ocp_req.cmd", 64'(ocp_req.cmd), burst_is_read ? 64'(RD) : 64'(WR));
      check_value("ocp_req.byte_en", 64'(ocp_req.byte_en), 64'(burst_be));
      check_value("ocp_req.req_last", 64'(ocp_req.req_last), 64'(beat_idx == burst_len - 1));
      if (burst_is_read) begin
        // Read beats carry no data
        check_value("ocp_req.data", 64'(ocp_req.data), 64'(0));
        // Each read beat gets one response with fresh data
        rsp.resp = pick_response();
        rsp.data = data_t'($urandom);
        rsp.last = ocp_req.req_last;
        resp_pending.push_back(rsp);
      end else begin
        check_value("ocp_req.data", 64'(ocp_req.data), 64'(wdata[beat_idx]));
        if (!ocp_req.req_last) begin
          next_data_idx = beat_idx + 2;
        end
      end
      beat_idx++;
      if (ocp_req.req_last) begin
        burst_open = 1'b0;
      end
    end
  endtask

  // Random accept, random tready, delayed slave responses
  task automatic drive_slave_and_sink();
    SCmdAccept    = ($urandom % 4) != 0;
    s_axis_tready = ($urandom % 3) != 0;
    if (next_data_idx >= 0) begin
      write_data    = wdata[next_data_idx];
      next_data_idx = -1;
    end
    if (ocp_resp.resp != NULL && !resp_taken) begin
      // Slave holds its response until MRespAccept
      resp_hold++;
      if (resp_hold > HOLD_LIMIT) begin
        stop_with_failure("Timed out waiting for MRespAccept");
      end
    end else begin
      ocp_resp  = '0;
      resp_hold = 0;
      if (resp_delay > 0) begin
        resp_delay--;
      end else if (resp_pending.size() > 0) begin
        ocp_resp   = resp_pending.pop_front();
        resp_delay = $urandom % 3;
      end
    end
    resp_taken = 1'b0;
  endtask

  // Sample on the edge, drive 1 ns later
  always @(posedge Clk) begin
    if (!reset) begin
      if (dut.u_asserts.error_count != 0) begin
        stop_with_failure("A protocol assertion in the bound checker failed");
      end
      track_stream();
      track_response();
      track_request_beat();
    end
    #1;
    drive_slave_and_sink();
  end

  task automatic wait_for_ready();
    int cycles;
    cycles = 0;
    do begin
      @(posedge Clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_failure("Timed out waiting for ocp_ready");
      end
    end while (!ocp_ready);
    #1;
  endtask

  task automatic start_burst();
    logic both;
    burst_len     = 1 + int'($urandom % 8);
    burst_is_read = ($urandom % 2) == 1;
    both          = ($urandom % 8) == 0;
    burst_addr    = {$urandom, $urandom};
    burst_be      = byte_en_t'($urandom);
    for (int i = 0; i < 9; i++) begin
      wdata[i] = data_t'($urandom);
    end
    if (both) begin
      burst_is_read = 1'b1;
    end
    bridge_req.address      = burst_addr;
    bridge_req.burst_length = burst_len_t'(burst_len);
    bridge_req.burst_seq    = (($urandom % 4) == 0) ? WRAP : INCR;
    bridge_req.valid_bytes  = burst_be;
    read_request  = burst_is_read;
    write_request = !burst_is_read | both;
    write_data    = wdata[0];
    beat_idx      = 0;
    burst_open    = 1'b1;
    @(posedge Clk);
    #1;
    read_request       = 1'b0;
    write_request      = 1'b0;
    write_data         = wdata[1];
    bridge_req.address = ~burst_addr;
  endtask

  task automatic wait_for_burst_end();
    int cycles;
    cycles = 0;
    while (burst_open) begin
      @(posedge Clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_failure("Timed out waiting for the burst to finish");
      end
    end
  endtask

  // All responses answered and streamed out
  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (resp_pending.size() > 0 || ocp_resp.resp != NULL ||
           stream_expect.size() > 0 || s_axis_tvalid) begin
      @(posedge Clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_failure("Timed out waiting for the response path to drain");
      end
    end
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    reset         = 1'b1;
    bridge_req    = '0;
    read_request  = 1'b0;
    write_request = 1'b0;
    write_data    = '0;
    SCmdAccept    = 1'b0;
    ocp_resp      = '0;
    s_axis_tready = 1'b0;
    burst_open    = 1'b0;
    burst_is_read = 1'b0;
    burst_addr    = '0;
    burst_be      = '0;
    burst_len     = 1;
    beat_idx      = 0;
    next_data_idx = -1;
    resp_taken    = 1'b0;
    resp_delay    = 0;
    resp_hold     = 0;
    stream_words  = 0;
    repeat (10) @(posedge Clk);
    #1;
    reset = 1'b0;
    for (int n = 0; n < NUM_BURSTS; n++) begin
      wait_for_ready();
      start_burst();
      wait_for_burst_end();
    end
    wait_for_drain();
    if (stream_words == 0) begin
      stop_with_failure("Run ended without any stream words");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// ==== verilog/ocp_burst_tracker.sv ====
`timescale 1ns/1ps

module ocp_burst_tracker import ocp_master_pkg::*; #(
  parameter int ADDR_WIDTH = ocp_master_pkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = ocp_master_pkg::DATA_WIDTH
) (
  input  logic       Clk,
  input  logic       reset,
  input  logic       start,
  input  addr_t      address,
  input  burst_len_t burst_length,
  input  burst_seq_e burst_seq,
  input  logic       active,
  input  logic       SCmdAccept,
  output addr_t      beat_addr,
  output logic       req_last,
  output logic       burst_done
);

  // One data word in bytes
  localparam addr_t ADDR_STEP = ADDR_WIDTH'(DATA_WIDTH / 8);

  burst_len_t beat_count;
  addr_t      addr_q;
  logic       beat_accept;

  // Beat transferred this cycle
  assign beat_accept = active & SCmdAccept;

  // Beat counter
  always_ff @(posedge Clk) begin
    if (reset) begin
      beat_count <= '0;
    end else if (start) begin
      beat_count <= '0;
    end else if (beat_accept) begin
      beat_count <= beat_count + 1'b1;
    end
  end

  // Address generator
  always_ff @(posedge Clk) begin
    if (start) begin
      addr_q <= address;
    end else if (beat_accept) begin
      // Other sequences repeat the start address
      if (burst_seq == INCR) begin
        addr_q <= addr_q + ADDR_STEP;
      end
    end
  end

  assign beat_addr = addr_q;

  // Final beat of the burst
  assign req_last   = active & (beat_count == burst_len_t'(burst_length - 1'b1));
  assign burst_done = beat_accept & req_last;

endmodule

// ==== verilog/ocp_cmd_ctrl.sv ====
`timescale 1ns/1ps

module ocp_cmd_ctrl import ocp_master_pkg::*; (
  input  logic     Clk,
  input  logic     reset,
  input  logic     read_request,
  input  logic     write_request,
  input  logic     burst_done,
  output logic     start_write,
  output logic     start_read,
  output logic     active,
  output ocp_cmd_e cmd,
  output logic     ocp_ready
);

  ctrl_state_e state;
  ctrl_state_e state_next;

  // Next state and start pulses
  always_comb begin
    state_next  = state;
    start_read  = 1'b0;
    start_write = 1'b0;
    case (state)
      CTRL_IDLE: begin
        // Read has priority over write
        if (read_request) begin
          start_read = 1'b1;
          state_next = CTRL_READ;
        end else if (write_request) begin
          start_write = 1'b1;
          state_next  = CTRL_WRITE;
        end
      end
      CTRL_WRITE: begin
        // Leave once the final beat is accepted
        if (burst_done) begin
          state_next = CTRL_IDLE;
        end
      end
      CTRL_READ: begin
        if (burst_done) begin
          state_next = CTRL_IDLE;
        end
      end
      default: begin
        state_next = CTRL_IDLE;
      end
    endcase
  end

  // State register
  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= CTRL_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // MCmd decode from the current state
  always_comb begin
    case (state)
      CTRL_WRITE: cmd = WR;
      CTRL_READ:  cmd = RD;
      default:    cmd = IDLE;
    endcase
  end

  // Idle means free for a new burst
  assign ocp_ready = (state == CTRL_IDLE);
  assign active    = (state != CTRL_IDLE);

endmodule

// ==== verilog/ocp_master_pkg.sv ====
package ocp_master_pkg;

  // Default OCP widths
  parameter int ADDR_WIDTH      = 64;
  parameter int DATA_WIDTH      = 8;
  parameter int BURST_LEN_WIDTH = 10;

  // Vectors with a meaning of their own
  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [DATA_WIDTH-1:0]      byte_en_t;
  typedef logic [BURST_LEN_WIDTH-1:0] burst_len_t;

  // MCmd codes
  typedef enum logic [2:0] {
    IDLE = 3'b000,
    WR   = 3'b001,
    RD   = 3'b010,
    RDEX = 3'b011,
    RDL  = 3'b100,
    WRNP = 3'b101,
    WRC  = 3'b110,
    BCST = 3'b111
  } ocp_cmd_e;

  // SResp codes
  typedef enum logic [1:0] {
    NULL = 2'b00,
    DVA  = 2'b01,
    FAIL = 2'b10,
    ERR  = 2'b11
  } ocp_resp_e;

  // MBurstSeq codes, only INCR moves the address
  typedef enum logic [2:0] {
    INCR  = 3'b000,
    DFLT1 = 3'b001,
    WRAP  = 3'b010,
    DFLT2 = 3'b011,
    XOR   = 3'b100,
    STRM  = 3'b101,
    UNKN  = 3'b110,
    BLCK  = 3'b111
  } burst_seq_e;

  // Command FSM states
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_WRITE,
    CTRL_READ
  } ctrl_state_e;

  // Burst request from the bridge
  typedef struct packed {
    addr_t      address;
    burst_len_t burst_length;
    burst_seq_e burst_seq;
    byte_en_t   valid_bytes;
  } bridge_req_t;

  // OCP request group
  typedef struct packed {
    ocp_cmd_e   cmd;
    addr_t      addr;
    burst_len_t burst_length;
    burst_seq_e burst_seq;
    byte_en_t   byte_en;
    data_t      data;
    logic       req_last;
  } ocp_req_t;

  // OCP response group
  typedef struct packed {
    ocp_resp_e resp;
    data_t     data;
    logic      last;
  } ocp_resp_t;

endpackage

// ==== verilog/ocp_master_top.sv ====
`timescale 1ns/1ps

module ocp_master_top import ocp_master_pkg::*; #(
  parameter int ADDR_WIDTH = ocp_master_pkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = ocp_master_pkg::DATA_WIDTH
) (
  input  logic        Clk,
  input  logic        reset,

  // Bridge side
  input  bridge_req_t bridge_req,
  input  logic        read_request,
  input  logic        write_request,
  input  data_t       write_data,
  output logic        ocp_ready,

  // OCP request group
  output ocp_req_t    ocp_req,
  input  logic        SCmdAccept,

  // OCP response group
  input  ocp_resp_t   ocp_resp,
  output logic        MRespAccept,

  // AXI stream toward the bridge
  output logic        s_axis_tvalid,
  input  logic        s_axis_tready,
  output data_t       s_axis_tdata,
  output byte_en_t    s_axis_tkeep,
  output logic        s_axis_tlast
);

  // FSM to datapath
  logic     start_write;
  logic     start_read;
  logic     active;
  ocp_cmd_e cmd;

  // Tracker back to FSM and request regs
  addr_t    beat_addr;
  logic     req_last;
  logic     burst_done;

  // Command sequencing
  ocp_cmd_ctrl u_cmd_ctrl (
    .Clk           (Clk),
    .reset         (reset),
    .read_request  (read_request),
    .write_request (write_request),
    .burst_done    (burst_done),
    .start_write   (start_write),
    .start_read    (start_read),
    .active        (active),
    .cmd           (cmd),
    .ocp_ready     (ocp_ready)
  );

  // Beat count and address, length and sequence come from the held request
  ocp_burst_tracker #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_burst_tracker (
    .Clk          (Clk),
    .reset        (reset),
    .start        (start_write | start_read),
    .address      (bridge_req.address),
    .burst_length (ocp_req.burst_length),
    .burst_seq    (ocp_req.burst_seq),
    .active       (active),
    .SCmdAccept   (SCmdAccept),
    .beat_addr    (beat_addr),
    .req_last     (req_last),
    .burst_done   (burst_done)
  );

  ocp_req_regs #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_req_regs (
    .Clk        (Clk),
    .reset      (reset),
    .start      (start_write | start_read),
    .cmd        (cmd),
    .bridge_req (bridge_req),
    .write_data (write_data),
    .SCmdAccept (SCmdAccept),
    .req_last   (req_last),
    .beat_addr  (beat_addr),
    .ocp_req    (ocp_req)
  );

  ocp_resp_buffer #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_resp_buffer (
    .Clk           (Clk),
    .reset         (reset),
    .ocp_resp      (ocp_resp),
    .MRespAccept   (MRespAccept),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tlast  (s_axis_tlast)
  );

endmodule

// ==== verilog/ocp_req_regs.sv ====
`timescale 1ns/1ps

module ocp_req_regs import ocp_master_pkg::*; #(
  parameter int DATA_WIDTH = ocp_master_pkg::DATA_WIDTH
) (
  input  logic        Clk,
  input  logic        reset,
  input  logic        start,
  input  ocp_cmd_e    cmd,
  input  bridge_req_t bridge_req,
  input  data_t       write_data,
  input  logic        SCmdAccept,
  input  logic        req_last,
  input  addr_t       beat_addr,
  output ocp_req_t    ocp_req
);

  // Held burst attributes
  burst_len_t burst_length_q;
  burst_seq_e burst_seq_q;
  byte_en_t   byte_en_q;
  data_t      data_q;
  logic       beat_accept;

  assign beat_accept = (cmd != IDLE) & SCmdAccept;

  // Captured once per burst
  always_ff @(posedge Clk) begin
    if (reset) begin
      burst_length_q <= burst_len_t'(1);
      burst_seq_q    <= INCR;
      byte_en_q      <= '1;
    end else if (start) begin
      burst_length_q <= bridge_req.burst_length;
      burst_seq_q    <= bridge_req.burst_seq;
      byte_en_q      <= bridge_req.valid_bytes;
    end
  end

  // Write data advances one beat per accept
  always_ff @(posedge Clk) begin
    if (start) begin
      data_q <= write_data;
    end else if (beat_accept && !req_last) begin
      data_q <= write_data;
    end
  end

  // Request group
  always_comb begin
    ocp_req.cmd          = cmd;
    ocp_req.addr         = beat_addr;
    ocp_req.burst_length = burst_length_q;
    ocp_req.burst_seq    = burst_seq_q;
    ocp_req.byte_en      = byte_en_q;
    // No data on reads
    ocp_req.data         = (cmd == WR) ? data_q : {DATA_WIDTH{1'b0}};
    ocp_req.req_last     = req_last;
  end

endmodule

// ==== verilog/ocp_resp_buffer.sv ====
`timescale 1ns/1ps

module ocp_resp_buffer import ocp_master_pkg::*; #(
  parameter int DATA_WIDTH = ocp_master_pkg::DATA_WIDTH
) (
  input  logic      Clk,
  input  logic      reset,
  input  ocp_resp_t ocp_resp,
  output logic      MRespAccept,
  output logic      s_axis_tvalid,
  input  logic      s_axis_tready,
  output data_t     s_axis_tdata,
  output byte_en_t  s_axis_tkeep,
  output logic      s_axis_tlast
);

  logic  full_q;
  data_t data_q;
  logic  last_q;
  logic  keep_resp;

  // Room when empty or draining this cycle
  assign MRespAccept = !full_q | s_axis_tready;

  // DVA and FAIL go on, ERR is dropped
  assign keep_resp = MRespAccept &
                     ((ocp_resp.resp == DVA) || (ocp_resp.resp == FAIL));

  // Occupancy
  always_ff @(posedge Clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (keep_resp) begin
      full_q <= 1'b1;
    end else if (s_axis_tready) begin
      full_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge Clk) begin
    if (keep_resp) begin
      data_q <= ocp_resp.data;
      last_q <= ocp_resp.last;
    end
  end

  // Stream side
  assign s_axis_tvalid = full_q;
  assign s_axis_tdata  = data_q;
  assign s_axis_tlast  = last_q;
  // Whole word always valid
  assign s_axis_tkeep  = {DATA_WIDTH{1'b1}};

endmodule

// ==== vlog.f ====
verilog/ocp_master_pkg.sv
verilog/ocp_cmd_ctrl.sv
verilog/ocp_burst_tracker.sv
verilog/ocp_req_regs.sv
verilog/ocp_resp_buffer.sv
verilog/ocp_master_top.sv
verification/ocp_master_asserts.sv
verification/ocp_master_tb.sv
